// File: all.f
cv_pkg.sv
cv_ce_divider.sv
cv_cart_loader.sv
cv_keypad_port.sv
cv_ram_window.sv
cv_io_top.sv
tb_cv_io.sv

// File: cv_cart_loader.sv
`timescale 1ns/1ps
`default_nettype none

module cv_cart_loader (
        input  wire                  clk_sys,
        input  wire                  reset_i,
        input  wire                  user_reset_i,
        input  wire                  ioctl_download_i,
        input  wire                  ioctl_wr_i,
        input  cv_pkg::ioctl_addr_t  ioctl_addr_i,
        input  wire [7:0]            ioctl_index_i,
        input  wire [7:0]            ioctl_dout_i,
        output logic                 sg1000_o,
        output logic                 extram_o,
        output cv_pkg::cart_pages_t  cart_pages_o,
        output logic                 cart_ready_o,
        output logic                 console_reset_o
);

        cv_pkg::loader_state_t state_q;
        cv_pkg::loader_state_t state_d;
        logic                  wr_take;
        logic                  in_extram_page;

        // ======================================================================
        // Download FSM
        // ======================================================================

        always_comb begin
                state_d = state_q;
                case (state_q)
                        cv_pkg::ld_idle: begin
                                if (ioctl_download_i) state_d = cv_pkg::ld_load;
                        end
                        cv_pkg::ld_load: begin
                                if (!ioctl_download_i) state_d = cv_pkg::ld_done;
                        end
                        cv_pkg::ld_done: begin
                                // A new image may be loaded at any time
                                if (ioctl_download_i) state_d = cv_pkg::ld_load;
                        end
                        default: state_d = cv_pkg::ld_idle;
                endcase
        end

        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        state_q <= cv_pkg::ld_idle;
                end else begin
                        state_q <= state_d;
                end
        end

        // Strobes count once the FSM has seen the download start
        assign wr_take        = ioctl_wr_i && ioctl_download_i && (state_q == cv_pkg::ld_load);
        assign in_extram_page = (ioctl_addr_i[24:13] == cv_pkg::extram_page);

        // ======================================================================
        // Format flags and page count
        // ======================================================================

        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        sg1000_o     <= 1'b0;
                        extram_o     <= 1'b0;
                        cart_pages_o <= '0;
                end else if (wr_take) begin
                        cart_pages_o <= ioctl_addr_i[19:14];
                        // First byte of an image decides the format
                        if (ioctl_addr_i == '0) begin
                                extram_o <= 1'b0;
                                sg1000_o <= (ioctl_index_i[4:0] == cv_pkg::sg1000_index);
                        end
                        // SG-1000 carts with RAM at 2000-3FFF ship that window as all FF
                        if (in_extram_page && sg1000_o) begin
                                extram_o <= ((ioctl_addr_i[12:0] == '0) || extram_o) &&
                                            (ioctl_dout_i == 8'hFF);
                        end
                end
        end

        assign cart_ready_o = (state_q == cv_pkg::ld_done);

        // Console stays in reset for the whole load
        assign console_reset_o = reset_i | user_reset_i | (state_q == cv_pkg::ld_load);

endmodule

`default_nettype wire

// File: cv_ce_divider.sv
`timescale 1ns/1ps
`default_nettype none

module cv_ce_divider (
        input  wire  clk_sys,
        input  wire  reset_i,
        output logic ce_10m7_o,
        output logic ce_5m3_o
);

        logic [cv_pkg::ce_div_width-1:0] div_q;
        logic [cv_pkg::ce_div_width-1:0] div_next;

        assign div_next = div_q + 1'b1;

        // Free-running divide counter
        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        div_q <= '0;
                end else begin
                        div_q <= div_next;
                end
        end

        // Pulses fire as the low counter bits wrap to zero,
        // so the slow enable always lands on a fast one
        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        ce_10m7_o <= 1'b0;
                        ce_5m3_o  <= 1'b0;
                end else begin
                        ce_10m7_o <= (div_next[1:0] == 2'b00);
                        ce_5m3_o  <= (div_next == '0);
                end
        end

endmodule

`default_nettype wire

// File: cv_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module cv_io_top (
        input  wire                   clk_sys,
        input  wire                   reset_i,
        input  wire                   user_reset_i,

        // Download bus
        input  wire                   ioctl_download_i,
        input  wire                   ioctl_wr_i,
        input  cv_pkg::ioctl_addr_t   ioctl_addr_i,
        input  wire [7:0]             ioctl_index_i,
        input  wire [7:0]             ioctl_dout_i,

        // Controllers
        input  cv_pkg::joy_t          joy0_i,
        input  cv_pkg::joy_t          joy1_i,
        input  wire                   swap_i,
        input  wire [1:0]             sel_keys_n_i,
        input  wire [1:0]             sel_joy_n_i,

        // CPU RAM
        input  cv_pkg::cpu_ram_addr_t cpu_ram_a_i,
        input  cv_pkg::ram_size_t     ram_size_i,
        input  wire                   adam_i,

        output logic [3:0]            ctrl0_n_o,
        output logic [3:0]            ctrl1_n_o,
        output logic [1:0]            fire_n_o,
        output cv_pkg::cpu_ram_addr_t ram_a_o,
        output logic                  sg1000_o,
        output logic                  extram_o,
        output cv_pkg::cart_pages_t   cart_pages_o,
        output logic                  cart_ready_o,
        output logic                  console_reset_o,
        output logic                  ce_10m7_o,
        output logic                  ce_5m3_o
);

        cv_pkg::joy_t joy_a;
        cv_pkg::joy_t joy_b;

        // Menu option to exchange the two pads
        assign joy_a = swap_i ? joy1_i : joy0_i;
        assign joy_b = swap_i ? joy0_i : joy1_i;

        cv_ce_divider u_ce_divider (
                .clk_sys   (clk_sys),
                .reset_i   (reset_i),
                .ce_10m7_o (ce_10m7_o),
                .ce_5m3_o  (ce_5m3_o)
        );

        cv_cart_loader u_cart_loader (
                .clk_sys          (clk_sys),
                .reset_i          (reset_i),
                .user_reset_i     (user_reset_i),
                .ioctl_download_i (ioctl_download_i),
                .ioctl_wr_i       (ioctl_wr_i),
                .ioctl_addr_i     (ioctl_addr_i),
                .ioctl_index_i    (ioctl_index_i),
                .ioctl_dout_i     (ioctl_dout_i),
                .sg1000_o         (sg1000_o),
                .extram_o         (extram_o),
                .cart_pages_o     (cart_pages_o),
                .cart_ready_o     (cart_ready_o),
                .console_reset_o  (console_reset_o)
        );

        // Window follows the cartridge flags of the last download
        cv_ram_window u_ram_window (
                .cpu_ram_a_i (cpu_ram_a_i),
                .ram_size_i  (ram_size_i),
                .sg1000_i    (sg1000_o),
                .extram_i    (extram_o),
                .adam_i      (adam_i),
                .ram_a_o     (ram_a_o)
        );

        cv_keypad_port u_keypad_port0 (
                .joy_i        (joy_a),
                .sel_keys_n_i (sel_keys_n_i[0]),
                .sel_joy_n_i  (sel_joy_n_i[0]),
                .ctrl_n_o     (ctrl0_n_o),
                .fire_n_o     (fire_n_o[0])
        );

        cv_keypad_port u_keypad_port1 (
                .joy_i        (joy_b),
                .sel_keys_n_i (sel_keys_n_i[1]),
                .sel_joy_n_i  (sel_joy_n_i[1]),
                .ctrl_n_o     (ctrl1_n_o),
                .fire_n_o     (fire_n_o[1])
        );

endmodule

`default_nettype wire

// File: cv_keypad_port.sv
`timescale 1ns/1ps
`default_nettype none

module cv_keypad_port (
        input  cv_pkg::joy_t joy_i,
        input  wire          sel_keys_n_i,
        input  wire          sel_joy_n_i,
        output logic [3:0]   ctrl_n_o,
        output logic         fire_n_o
);

        cv_pkg::keycode_t keys_code;
        logic             keys_fire_n;
        logic [3:0]       joy_dir_n;
        logic             joy_fire_n;

        // ======================================================================
        // Keypad side
        // ======================================================================

        // Lowest digit wins when several keys are down
        always_comb begin
                keys_code   = cv_pkg::key_none;
                keys_fire_n = 1'b1;
                if (!sel_keys_n_i) begin
                        if (joy_i[cv_pkg::joy_digit0]) begin
                                keys_code = cv_pkg::key_0;
                        end else if (joy_i[cv_pkg::joy_digit0 + 1]) begin
                                keys_code = cv_pkg::key_1;
                        end else if (joy_i[cv_pkg::joy_digit0 + 2]) begin
                                keys_code = cv_pkg::key_2;
                        end else if (joy_i[cv_pkg::joy_digit0 + 3]) begin
                                keys_code = cv_pkg::key_3;
                        end else if (joy_i[cv_pkg::joy_digit0 + 4]) begin
                                keys_code = cv_pkg::key_4;
                        end else if (joy_i[cv_pkg::joy_digit0 + 5]) begin
                                keys_code = cv_pkg::key_5;
                        end else if (joy_i[cv_pkg::joy_digit0 + 6]) begin
                                keys_code = cv_pkg::key_6;
                        end else if (joy_i[cv_pkg::joy_digit0 + 7]) begin
                                keys_code = cv_pkg::key_7;
                        end else if (joy_i[cv_pkg::joy_digit0 + 8]) begin
                                keys_code = cv_pkg::key_8;
                        end else if (joy_i[cv_pkg::joy_digit0 + 9]) begin
                                keys_code = cv_pkg::key_9;
                        end else if (joy_i[cv_pkg::joy_asterisk]) begin
                                keys_code = cv_pkg::key_asterisk;
                        end else if (joy_i[cv_pkg::joy_number]) begin
                                keys_code = cv_pkg::key_number;
                        end else if (joy_i[cv_pkg::joy_purple]) begin
                                keys_code = cv_pkg::key_purple;
                        end else if (joy_i[cv_pkg::joy_blue]) begin
                                keys_code = cv_pkg::key_blue;
                        end
                        // Fire 2 shares the fire line in keypad mode
                        keys_fire_n = ~joy_i[cv_pkg::joy_fire2];
                end
        end

        // ======================================================================
        // Joystick side
        // ======================================================================

        always_comb begin
                joy_dir_n  = 4'b1111;
                joy_fire_n = 1'b1;
                if (!sel_joy_n_i) begin
                        // Nibble order is up, down, left, right
                        joy_dir_n  = ~{joy_i[cv_pkg::joy_up],
                                       joy_i[cv_pkg::joy_down],
                                       joy_i[cv_pkg::joy_left],
                                       joy_i[cv_pkg::joy_right]};
                        joy_fire_n = ~joy_i[cv_pkg::joy_fire1];
                end
        end

        // Both selects low means both sides pull the lines
        assign ctrl_n_o = keys_code & joy_dir_n;
        assign fire_n_o = keys_fire_n & joy_fire_n;

endmodule

`default_nettype wire

// File: cv_pkg.sv
`default_nettype none

package cv_pkg;

        // ======================================================================
        // Widths that carry a meaning
        // ======================================================================

        typedef logic [19:0] joy_t;
        typedef logic [3:0]  keycode_t;
        typedef logic [24:0] ioctl_addr_t;
        typedef logic [14:0] cpu_ram_addr_t;
        typedef logic [5:0]  cart_pages_t;
        typedef logic [1:0]  ram_size_t;

        // Download FSM
        typedef enum logic [1:0] {
                ld_idle,
                ld_load,
                ld_done
        } loader_state_t;

        // RAM size setting from the menu
        localparam ram_size_t ram_size_1k  = 2'd0;
        localparam ram_size_t ram_size_8k  = 2'd1;
        localparam ram_size_t ram_size_sgm = 2'd2;

        // Bit positions in the joystick word
        localparam int joy_right    = 0;
        localparam int joy_left     = 1;
        localparam int joy_down     = 2;
        localparam int joy_up       = 3;
        localparam int joy_fire1    = 4;
        localparam int joy_fire2    = 5;
        localparam int joy_asterisk = 6;
        localparam int joy_number   = 7;
        localparam int joy_digit0   = 8;
        localparam int joy_purple   = 18;
        localparam int joy_blue     = 19;

        // ======================================================================
        // Keypad codes as seen on the controller lines
        // ======================================================================

        localparam keycode_t key_0        = 4'b0011;
        localparam keycode_t key_1        = 4'b1110;
        localparam keycode_t key_2        = 4'b1101;
        localparam keycode_t key_3        = 4'b0110;
        localparam keycode_t key_4        = 4'b0001;
        localparam keycode_t key_5        = 4'b1001;
        localparam keycode_t key_6        = 4'b0111;
        localparam keycode_t key_7        = 4'b1100;
        localparam keycode_t key_8        = 4'b1000;
        localparam keycode_t key_9        = 4'b1011;
        localparam keycode_t key_asterisk = 4'b1010;
        localparam keycode_t key_number   = 4'b0101;
        localparam keycode_t key_purple   = 4'b0100;
        localparam keycode_t key_blue     = 4'b0010;
        localparam keycode_t key_none     = 4'b1111;

        // Download index of an SG-1000 image (low 5 bits)
        localparam logic [4:0] sg1000_index = 5'd2;

        // 8 KB page of the 2000-3FFF window
        localparam logic [11:0] extram_page = 12'd1;

        localparam int ce_div_width = 3;

endpackage

`default_nettype wire

// File: cv_ram_window.sv
`timescale 1ns/1ps
`default_nettype none

module cv_ram_window (
        input  cv_pkg::cpu_ram_addr_t cpu_ram_a_i,
        input  cv_pkg::ram_size_t     ram_size_i,
        input  wire                   sg1000_i,
        input  wire                   extram_i,
        input  wire                   adam_i,
        output cv_pkg::cpu_ram_addr_t ram_a_o
);

        cv_pkg::cpu_ram_addr_t keep_mask;

        // Number of address bits that reach the RAM
        always_comb begin
                if (extram_i || adam_i) begin
                        keep_mask = '1;
                end else if (ram_size_i == cv_pkg::ram_size_8k) begin
                        keep_mask = 15'h1FFF;
                end else if (ram_size_i == cv_pkg::ram_size_1k) begin
                        keep_mask = 15'h03FF;
                end else if (sg1000_i) begin
                        // SGM on an SG-1000 cart behaves as 8K
                        keep_mask = 15'h1FFF;
                end else begin
                        keep_mask = '1;
                end
        end

        assign ram_a_o = cpu_ram_a_i & keep_mask;

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for failures
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_cv_io \
        -f all.f -o tb_cv_io \
        && ./obj_dir/tb_cv_io | tee sim.log \
        || exit 1

grep -q "Errors found" sim.log && exit 1 || exit 0

// File: tb_cv_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cv_io;

        localparam int key_rows  = 8;
        localparam int rand_rows = 48;
        localparam int ram_rows  = 10;
        // One download is the first byte, the 8 KB window and the last byte, two cycles each
        localparam int load_cycles    = 2 * (8192 + 2) + 8;
        localparam int test_cycles    = 5 + 64 + key_rows + rand_rows + 3 * load_cycles
                                        + ram_rows + 16;
        localparam int timeout_cycles = 2 * test_cycles;
        localparam cv_pkg::ioctl_addr_t last_addr = 25'h24000;

        typedef struct packed {
                logic       swap;
                logic [1:0] keys_n;
                logic [1:0] joy_n;
                logic [19:0] j0;
                logic [19:0] j1;
                logic [3:0] c0;
                logic [3:0] c1;
                logic [1:0] fire;
        } key_row_t;

        typedef struct packed {
                logic [1:0]            phase;
                cv_pkg::cpu_ram_addr_t addr;
                cv_pkg::ram_size_t     size;
                logic                  adam;
                cv_pkg::cpu_ram_addr_t exp_a;
        } ram_row_t;

        logic                  clk_sys;
        logic                  reset_i;
        logic                  user_reset_i;
        logic                  ioctl_download_i;
        logic                  ioctl_wr_i;
        cv_pkg::ioctl_addr_t   ioctl_addr_i;
        logic [7:0]            ioctl_index_i;
        logic [7:0]            ioctl_dout_i;
        cv_pkg::joy_t          joy0_i;
        cv_pkg::joy_t          joy1_i;
        logic                  swap_i;
        logic [1:0]            sel_keys_n_i;
        logic [1:0]            sel_joy_n_i;
        cv_pkg::cpu_ram_addr_t cpu_ram_a_i;
        cv_pkg::ram_size_t     ram_size_i;
        logic                  adam_i;
        logic [3:0]            ctrl0_n_o;
        logic [3:0]            ctrl1_n_o;
        logic [1:0]            fire_n_o;
        cv_pkg::cpu_ram_addr_t ram_a_o;
        logic                  sg1000_o;
        logic                  extram_o;
        cv_pkg::cart_pages_t   cart_pages_o;
        logic                  cart_ready_o;
        logic                  console_reset_o;
        logic                  ce_10m7_o;
        logic                  ce_5m3_o;

        int checks      = 0;
        int errors      = 0;
        int cycle_count = 0;

        // Keypad priority, highest first: digits 0 to 9, asterisk, number, purple, blue
        int key_bits [14] = '{8, 9, 10, 11, 12, 13, 14, 15, 16, 17, 6, 7, 18, 19};
        cv_pkg::keycode_t key_codes [14] = '{cv_pkg::key_0, cv_pkg::key_1, cv_pkg::key_2,
                cv_pkg::key_3, cv_pkg::key_4, cv_pkg::key_5, cv_pkg::key_6, cv_pkg::key_7,
                cv_pkg::key_8, cv_pkg::key_9, cv_pkg::key_asterisk, cv_pkg::key_number,
                cv_pkg::key_purple, cv_pkg::key_blue};

        // swap, keys_n, joy_n, joy0, joy1, ctrl0, ctrl1, fire
        key_row_t key_table [key_rows] = '{
                '{1'b0, 2'b00, 2'b11, 20'h88800, 20'h00000, 4'b0110, 4'b1111, 2'b11},
                '{1'b0, 2'b00, 2'b11, 20'h00160, 20'h40080, 4'b0011, 4'b0101, 2'b10},
                '{1'b0, 2'b11, 2'b00, 20'h00019, 20'h02006, 4'b0110, 4'b1001, 2'b10},
                '{1'b0, 2'b00, 2'b00, 20'h20018, 20'h00021, 4'b0011, 4'b1110, 2'b00},
                '{1'b0, 2'b11, 2'b11, 20'hFFFFF, 20'hFFFFF, 4'b1111, 4'b1111, 2'b11},
                '{1'b1, 2'b00, 2'b11, 20'h00400, 20'h00040, 4'b1010, 4'b1101, 2'b11},
                '{1'b1, 2'b11, 2'b00, 20'h00012, 20'h00008, 4'b0111, 4'b1101, 2'b01},
                '{1'b0, 2'b10, 2'b01, 20'h80000, 20'h0001C, 4'b0010, 4'b0011, 2'b01}
        };

        // Phase 0 after the SG-1000 load with RAM, 1 after the bad byte, 2 after index 1
        ram_row_t ram_table [ram_rows] = '{
                '{2'd0, 15'h7FFF, cv_pkg::ram_size_1k,  1'b0, 15'h7FFF},
                '{2'd0, 15'h5A5A, cv_pkg::ram_size_8k,  1'b0, 15'h5A5A},
                '{2'd1, 15'h7FFF, cv_pkg::ram_size_8k,  1'b0, 15'h1FFF},
                '{2'd1, 15'h7FFF, cv_pkg::ram_size_1k,  1'b0, 15'h03FF},
                '{2'd1, 15'h7FFF, cv_pkg::ram_size_sgm, 1'b0, 15'h1FFF},
                '{2'd1, 15'h7FFF, cv_pkg::ram_size_sgm, 1'b1, 15'h7FFF},
                '{2'd2, 15'h6ABC, cv_pkg::ram_size_sgm, 1'b0, 15'h6ABC},
                '{2'd2, 15'h6ABC, cv_pkg::ram_size_8k,  1'b0, 15'h0ABC},
                '{2'd2, 15'h6ABC, cv_pkg::ram_size_1k,  1'b0, 15'h02BC},
                '{2'd2, 15'h6ABC, cv_pkg::ram_size_1k,  1'b1, 15'h6ABC}
        };

        cv_io_top DUT (
                .clk_sys          (clk_sys),
                .reset_i          (reset_i),
                .user_reset_i     (user_reset_i),
                .ioctl_download_i (ioctl_download_i),
                .ioctl_wr_i       (ioctl_wr_i),
                .ioctl_addr_i     (ioctl_addr_i),
                .ioctl_index_i    (ioctl_index_i),
                .ioctl_dout_i     (ioctl_dout_i),
                .joy0_i           (joy0_i),
                .joy1_i           (joy1_i),
                .swap_i           (swap_i),
                .sel_keys_n_i     (sel_keys_n_i),
                .sel_joy_n_i      (sel_joy_n_i),
                .cpu_ram_a_i      (cpu_ram_a_i),
                .ram_size_i       (ram_size_i),
                .adam_i           (adam_i),
                .ctrl0_n_o        (ctrl0_n_o),
                .ctrl1_n_o        (ctrl1_n_o),
                .fire_n_o         (fire_n_o),
                .ram_a_o          (ram_a_o),
                .sg1000_o         (sg1000_o),
                .extram_o         (extram_o),
                .cart_pages_o     (cart_pages_o),
                .cart_ready_o     (cart_ready_o),
                .console_reset_o  (console_reset_o),
                .ce_10m7_o        (ce_10m7_o),
                .ce_5m3_o         (ce_5m3_o)
        );

        initial begin
                clk_sys = 1'b0;
                forever #4 clk_sys = ~clk_sys;
        end

        always @(posedge clk_sys) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= timeout_cycles) begin
                        $display("Timeout after %0d cycles with %0d errors", cycle_count, errors);
                        $display("Errors found");
                        $finish;
                end
        end

        // ======================================================================
        // Checker and reference model
        // ======================================================================

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
                checks++;
                if (got !== expected) begin
                        errors++;
                        $display("error: %s = 0x%0h, expected 0x%0h at %0t",
                                 name, got, expected, $time);
                end
        endtask

        // Returns {ctrl nibble, fire line} of one port
        function automatic logic [4:0] port_model(input cv_pkg::joy_t j, input logic keys_n,
                                                  input logic joy_n);
                logic [3:0] code;
                logic [3:0] dir;
                logic       fire_k;
                logic       fire_j;
                int         i;
                code   = cv_pkg::key_none;
                dir    = 4'b1111;
                fire_k = 1'b1;
                fire_j = 1'b1;
                if (!keys_n) begin
                        // Lowest priority first so the winner is written last
                        for (i = 13; i >= 0; i--) begin
                                if (j[key_bits[i]]) code = key_codes[i];
                        end
                        fire_k = !j[5];
                end
                if (!joy_n) begin
                        dir    = ~{j[3], j[2], j[1], j[0]};
                        fire_j = !j[4];
                end
                return {code & dir, fire_k & fire_j};
        endfunction

        task automatic apply_port_row(input logic swap, input logic [1:0] keys_n,
                                      input logic [1:0] joy_n, input cv_pkg::joy_t j0,
                                      input cv_pkg::joy_t j1, input logic [3:0] c0,
                                      input logic [3:0] c1, input logic [1:0] fire);
                @(negedge clk_sys);
                swap_i       = swap;
                sel_keys_n_i = keys_n;
                sel_joy_n_i  = joy_n;
                joy0_i       = j0;
                joy1_i       = j1;
                @(posedge clk_sys);
                check_value("ctrl0_n_o", 32'(ctrl0_n_o), 32'(c0));
                check_value("ctrl1_n_o", 32'(ctrl1_n_o), 32'(c1));
                check_value("fire_n_o", 32'(fire_n_o), 32'(fire));
        endtask

        task automatic random_port_rows();
                logic [31:0]  rnd;
                cv_pkg::joy_t j0;
                cv_pkg::joy_t j1;
                logic [4:0]   exp0;
                logic [4:0]   exp1;
                int           i;
                for (i = 0; i < rand_rows; i++) begin
                        rnd  = $urandom;
                        j0   = rnd[19:0];
                        rnd  = $urandom;
                        j1   = rnd[19:0];
                        rnd  = $urandom;
                        exp0 = port_model(rnd[0] ? j1 : j0, rnd[1], rnd[3]);
                        exp1 = port_model(rnd[0] ? j0 : j1, rnd[2], rnd[4]);
                        apply_port_row(rnd[0], rnd[2:1], rnd[4:3], j0, j1, exp0[4:1], exp1[4:1],
                                       {exp1[0], exp0[0]});
                end
        endtask

        // ======================================================================
        // Download bus
        // ======================================================================

        task automatic write_byte(input cv_pkg::ioctl_addr_t addr, input logic [7:0] data);
                @(negedge clk_sys);
                ioctl_wr_i   = 1'b1;
                ioctl_addr_i = addr;
                ioctl_dout_i = data;
                @(negedge clk_sys);
                ioctl_wr_i = 1'b0;
                check_value("console_reset_o", 32'(console_reset_o), 32'd1);
        endtask

        // Image with a header byte, the 2000-3FFF window and one byte far up
        task automatic load_image(input logic [7:0] index, input cv_pkg::ioctl_addr_t bad_addr,
                                  input logic exp_sg, input logic exp_ext);
                cv_pkg::ioctl_addr_t a;
                @(negedge clk_sys);
                ioctl_download_i = 1'b1;
                ioctl_index_i    = index;
                write_byte(25'h0, 8'h31);
                for (a = 25'h2000; a <= 25'h3FFF; a++) begin
                        write_byte(a, (a == bad_addr) ? 8'h00 : 8'hFF);
                end
                write_byte(last_addr, 8'h5A);
                ioctl_download_i = 1'b0;
                @(negedge clk_sys);
                check_value("cart_ready_o", 32'(cart_ready_o), 32'd1);
                check_value("console_reset_o", 32'(console_reset_o), 32'd0);
                check_value("sg1000_o", 32'(sg1000_o), 32'(exp_sg));
                check_value("extram_o", 32'(extram_o), 32'(exp_ext));
                check_value("cart_pages_o", 32'(cart_pages_o), 32'(last_addr[19:14]));
        endtask

        task automatic ram_rows_for(input logic [1:0] phase);
                int i;
                for (i = 0; i < ram_rows; i++) begin
                        if (ram_table[i].phase == phase) begin
                                @(negedge clk_sys);
                                cpu_ram_a_i = ram_table[i].addr;
                                ram_size_i  = ram_table[i].size;
                                adam_i      = ram_table[i].adam;
                                @(posedge clk_sys);
                                check_value("ram_a_o", 32'(ram_a_o), 32'(ram_table[i].exp_a));
                        end
                end
        endtask

        // ======================================================================
        // Test sequence
        // ======================================================================

        initial begin
                int n10;
                int n5;
                int i;
                void'($urandom(13730));
                reset_i          = 1'b1;
                user_reset_i     = 1'b0;
                ioctl_download_i = 1'b0;
                ioctl_wr_i       = 1'b0;
                ioctl_addr_i     = '0;
                ioctl_index_i    = 8'h00;
                ioctl_dout_i     = 8'h00;
                joy0_i           = '0;
                joy1_i           = '0;
                swap_i           = 1'b0;
                sel_keys_n_i     = 2'b11;
                sel_joy_n_i      = 2'b11;
                cpu_ram_a_i      = '0;
                ram_size_i       = cv_pkg::ram_size_1k;
                adam_i           = 1'b0;
                n10              = 0;
                n5               = 0;

                repeat (4) @(negedge clk_sys);
                // Values held in reset
                check_value("ce_10m7_o", 32'(ce_10m7_o), 32'd0);
                check_value("ce_5m3_o", 32'(ce_5m3_o), 32'd0);
                check_value("cart_ready_o", 32'(cart_ready_o), 32'd0);
                check_value("cart_pages_o", 32'(cart_pages_o), 32'd0);
                check_value("sg1000_o", 32'(sg1000_o), 32'd0);
                check_value("extram_o", 32'(extram_o), 32'd0);
                reset_i = 1'b0;

                // First cycle after reset carries no enable
                @(negedge clk_sys);
                check_value("ce_10m7_o", 32'(ce_10m7_o), 32'd0);
                check_value("ce_5m3_o", 32'(ce_5m3_o), 32'd0);

                for (i = 0; i < 64; i++) begin
                        @(negedge clk_sys);
                        if (ce_10m7_o) n10++;
                        if (ce_5m3_o) begin
                                n5++;
                                check_value("ce_10m7_o", 32'(ce_10m7_o), 32'd1);
                        end
                end
                check_value("ce_10m7_o pulses", 32'(n10), 32'd16);
                check_value("ce_5m3_o pulses", 32'(n5), 32'd8);

                for (i = 0; i < key_rows; i++) begin
                        apply_port_row(key_table[i].swap, key_table[i].keys_n,
                                       key_table[i].joy_n, key_table[i].j0, key_table[i].j1,
                                       key_table[i].c0, key_table[i].c1, key_table[i].fire);
                end
                random_port_rows();

                load_image(8'h02, 25'h0, 1'b1, 1'b1);
                ram_rows_for(2'd0);
                load_image(8'h02, 25'h2A55, 1'b1, 1'b0);
                ram_rows_for(2'd1);
                load_image(8'h01, 25'h0, 1'b0, 1'b0);
                ram_rows_for(2'd2);

                @(negedge clk_sys);
                $display("Summary: %0d checks, %0d errors", checks, errors);
                if (errors == 0) begin
                        $display("No errors");
                end else begin
                        $display("Errors found");
                end
                $finish;
        end

endmodule

`default_nettype wire
